// File: Bender.yml
package:
  name: rs_main_control

sources:
  - files:
      - source/rs_ctrl_pkg.sv
      - source/rs_word_counters.sv
      - source/rs_stream_sequencer.sv
      - source/rs_decode_sequencer.sv
      - source/rs_main_control.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/rs_main_control_tb.sv

// File: source/rs_ctrl_pkg.sv
// Reed-Solomon decoder main control package
// Codeword sizing and the state encodings of the decode and stream sequencers

package rs_ctrl_pkg;

   // Symbols per codeword
   localparam int CODEWORD_LEN = 31;

   // Word counter width, wide enough to reach CODEWORD_LEN
   localparam int WORD_COUNT_W = 5;

   // Error-locator degree and Chien root count
   localparam int DEGREE_W = 3;

   // Per-codeword decode phases
   typedef enum logic [3:0] {
      ds_idle,
      ds_arm_receive,
      ds_receiving,
      ds_eval_syndrome,
      ds_errors_found,
      ds_solving,
      ds_start_search,
      ds_output_wait,
      ds_output_arm_next,
      ds_output_overlap,
      ds_fail_idle,
      ds_fail_next,
      ds_clean_output,
      ds_clean_arm_next,
      ds_clean_overlap
   } decode_state_t;

   // FIFO receive and output phases
   typedef enum logic [3:0] {
      ss_idle,
      ss_shift_in,
      ss_last_in,
      ss_hold,
      ss_out_prepare,
      ss_out_first,
      ss_out_shift,
      ss_out_done,
      ss_overlap_first,
      ss_overlap_shift,
      ss_overlap_done_full,
      ss_overlap_done_partial
   } stream_state_t;

endpackage

// File: source/rs_decode_sequencer.sv
// Reed-Solomon decode sequencer
// Walks each codeword through receive, syndrome, optional key-equation solve
// and root search, and flags a failure when locator degree and root count differ
`timescale 1ns/1ps

module rs_decode_sequencer (
   input  logic                             clock1,
   input  logic                             reset,
   input  logic                             start,
   input  logic                             err_detect,
   input  logic                             finish_kes,
   input  logic [rs_ctrl_pkg::DEGREE_W-1:0] root_count,
   input  logic [rs_ctrl_pkg::DEGREE_W-1:0] lambda_degree,
   input  logic                             data_in_finish,
   input  logic                             data_out_end,
   output logic                             ready,
   output logic                             active_sc,
   output logic                             active_kes,
   output logic                             active_csee,
   output logic                             eval_synd,
   output logic                             err_found,
   output logic                             decode_fail,
   output logic                             en_outfifo
);
   import rs_ctrl_pkg::*;

   decode_state_t state;
   decode_state_t next_state;
   logic          degree_match;
   logic          start_held;
   logic          rx_done_q;

   // A good decode finds one root per locator degree
   assign degree_match = (lambda_degree == root_count);

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state      <= ds_idle;
         start_held <= 1'b0;
         rx_done_q  <= 1'b0;
      end else begin
         state      <= next_state;
         // Start that arrived together with the end of a failed output
         start_held <= start && data_out_end && (state == ds_output_wait);
         rx_done_q  <= data_in_finish;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         ds_idle:
            if (start) next_state = ds_arm_receive;
         ds_arm_receive:
            next_state = ds_receiving;
         ds_receiving:
            if (data_in_finish) next_state = ds_eval_syndrome;
         ds_eval_syndrome:
            next_state = err_detect ? ds_errors_found : ds_clean_output;
         ds_errors_found:
            next_state = ds_solving;
         ds_solving:
            if (finish_kes) next_state = ds_start_search;
         ds_start_search:
            next_state = ds_output_wait;
         ds_output_wait: begin
            if (data_out_end) begin
               if (degree_match) begin
                  next_state = start ? ds_arm_receive : ds_idle;
               end else begin
                  next_state = ds_fail_idle;
               end
            end else if (start) begin
               next_state = ds_output_arm_next;
            end
         end
         ds_output_arm_next: begin
            if (data_out_end) begin
               next_state = degree_match ? ds_receiving : ds_fail_next;
            end else begin
               next_state = ds_output_overlap;
            end
         end
         ds_output_overlap: begin
            if (data_out_end) begin
               if (!degree_match) begin
                  next_state = ds_fail_next;
               end else if (data_in_finish) begin
                  next_state = ds_eval_syndrome;
               end else begin
                  next_state = ds_receiving;
               end
            end
         end
         ds_fail_idle:
            next_state = (start || start_held) ? ds_arm_receive : ds_idle;
         ds_fail_next:
            // The overlapped receive may already have ended
            next_state = (data_in_finish || rx_done_q) ? ds_eval_syndrome : ds_receiving;
         ds_clean_output: begin
            if (data_out_end) begin
               next_state = start ? ds_arm_receive : ds_idle;
            end else if (start) begin
               next_state = ds_clean_arm_next;
            end
         end
         ds_clean_arm_next:
            next_state = data_out_end ? ds_receiving : ds_clean_overlap;
         ds_clean_overlap: begin
            if (data_out_end) begin
               next_state = data_in_finish ? ds_eval_syndrome : ds_receiving;
            end
         end
         default:
            next_state = ds_idle;
      endcase
   end

   // Moore decode of the block activations and status
   always_comb begin
      ready       = 1'b0;
      active_sc   = 1'b0;
      active_kes  = 1'b0;
      active_csee = 1'b0;
      eval_synd   = 1'b0;
      err_found   = 1'b0;
      decode_fail = 1'b0;
      en_outfifo  = 1'b0;
      case (state)
         ds_idle:            ready = 1'b1;
         ds_arm_receive:     active_sc = 1'b1;
         ds_eval_syndrome:   eval_synd = 1'b1;
         ds_errors_found: begin
            err_found  = 1'b1;
            active_kes = 1'b1;
         end
         ds_solving:         active_kes = 1'b1;
         ds_start_search: begin
            active_kes  = 1'b1;
            active_csee = 1'b1;
         end
         ds_output_wait, ds_clean_output: begin
            ready      = 1'b1;
            en_outfifo = 1'b1;
         end
         ds_output_arm_next, ds_clean_arm_next: begin
            active_sc  = 1'b1;
            en_outfifo = 1'b1;
         end
         ds_output_overlap, ds_clean_overlap: en_outfifo = 1'b1;
         ds_fail_idle: begin
            ready       = 1'b1;
            decode_fail = 1'b1;
         end
         ds_fail_next:       decode_fail = 1'b1;
         default:            ready = 1'b0;
      endcase
   end

   a_err_found_pulse: assert property (
      @(posedge clock1) disable iff (!reset) err_found |=> !err_found);

   a_fail_not_in_output: assert property (
      @(posedge clock1) disable iff (!reset) !(decode_fail && en_outfifo));

endmodule

// File: source/rs_main_control.sv
// Reed-Solomon decoder main control
// Ties the decode sequencer, the FIFO stream sequencer and the word counters
`timescale 1ns/1ps

module rs_main_control (
   input  logic                             clock1,
   input  logic                             reset,
   input  logic                             start,
   input  logic                             err_detect,
   input  logic                             finish_kes,
   input  logic [rs_ctrl_pkg::DEGREE_W-1:0] root_count,
   input  logic [rs_ctrl_pkg::DEGREE_W-1:0] lambda_degree,
   output logic                             ready,
   output logic                             active_sc,
   output logic                             active_kes,
   output logic                             active_csee,
   output logic                             eval_synd,
   output logic                             hold_synd,
   output logic                             err_found,
   output logic                             decode_fail,
   output logic                             data_out_start,
   output logic                             data_out_end,
   output logic                             shift_fifo,
   output logic                             hold_fifo,
   output logic                             en_infifo,
   output logic                             en_outfifo,
   output logic                             last_data_out,
   output logic                             eval_error
);

   logic data_in_finish;
   logic count_in_en;
   logic count_out_en;
   logic last_word_in;
   logic last_word_out;

   rs_decode_sequencer i_rs_decode_sequencer (
      .clock1         (clock1),
      .reset          (reset),
      .start          (start),
      .err_detect     (err_detect),
      .finish_kes     (finish_kes),
      .root_count     (root_count),
      .lambda_degree  (lambda_degree),
      .data_in_finish (data_in_finish),
      .data_out_end   (data_out_end),
      .ready          (ready),
      .active_sc      (active_sc),
      .active_kes     (active_kes),
      .active_csee    (active_csee),
      .eval_synd      (eval_synd),
      .err_found      (err_found),
      .decode_fail    (decode_fail),
      .en_outfifo     (en_outfifo)
   );

   rs_stream_sequencer i_rs_stream_sequencer (
      .clock1         (clock1),
      .reset          (reset),
      .active_sc      (active_sc),
      .en_outfifo     (en_outfifo),
      .last_word_in   (last_word_in),
      .last_word_out  (last_word_out),
      .shift_fifo     (shift_fifo),
      .hold_fifo      (hold_fifo),
      .en_infifo      (en_infifo),
      .hold_synd      (hold_synd),
      .data_in_finish (data_in_finish),
      .data_out_start (data_out_start),
      .data_out_end   (data_out_end),
      .count_in_en    (count_in_en),
      .count_out_en   (count_out_en)
   );

   rs_word_counters i_rs_word_counters (
      .clock1        (clock1),
      .reset         (reset),
      .count_in_en   (count_in_en),
      .count_out_en  (count_out_en),
      .last_word_in  (last_word_in),
      .last_word_out (last_word_out),
      .last_data_out (last_data_out),
      .eval_error    (eval_error)
   );

endmodule

// File: source/rs_stream_sequencer.sv
// Reed-Solomon codeword FIFO sequencer
// Runs the receive, hold and output phases of the FIFO and lets the next
// codeword shift in while the previous one is still going out
`timescale 1ns/1ps

module rs_stream_sequencer (
   input  logic clock1,
   input  logic reset,
   input  logic active_sc,
   input  logic en_outfifo,
   input  logic last_word_in,
   input  logic last_word_out,
   output logic shift_fifo,
   output logic hold_fifo,
   output logic en_infifo,
   output logic hold_synd,
   output logic data_in_finish,
   output logic data_out_start,
   output logic data_out_end,
   output logic count_in_en,
   output logic count_out_en
);
   import rs_ctrl_pkg::*;

   stream_state_t state;
   stream_state_t next_state;

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state <= ss_idle;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         ss_idle:
            if (active_sc) next_state = ss_shift_in;
         ss_shift_in:
            if (last_word_in) next_state = ss_last_in;
         ss_last_in:
            next_state = ss_hold;
         ss_hold:
            if (en_outfifo) next_state = ss_out_prepare;
         ss_out_prepare:
            next_state = active_sc ? ss_overlap_first : ss_out_first;
         ss_out_first:
            next_state = active_sc ? ss_overlap_shift : ss_out_shift;
         ss_out_shift: begin
            if (last_word_out) begin
               // A start on the final output word begins receiving at once
               next_state = active_sc ? ss_overlap_done_partial : ss_out_done;
            end else if (active_sc) begin
               next_state = ss_overlap_shift;
            end
         end
         ss_out_done:
            next_state = active_sc ? ss_shift_in : ss_idle;
         ss_overlap_first:
            next_state = ss_overlap_shift;
         ss_overlap_shift: begin
            if (last_word_out) begin
               next_state = last_word_in ? ss_overlap_done_full : ss_overlap_done_partial;
            end
         end
         ss_overlap_done_full:
            next_state = ss_hold;
         ss_overlap_done_partial:
            next_state = last_word_in ? ss_last_in : ss_shift_in;
         default:
            next_state = ss_idle;
      endcase
   end

   // Moore decode of the FIFO controls and counter enables
   always_comb begin
      shift_fifo     = 1'b0;
      hold_fifo      = 1'b0;
      en_infifo      = 1'b0;
      hold_synd      = 1'b0;
      data_in_finish = 1'b0;
      data_out_start = 1'b0;
      data_out_end   = 1'b0;
      count_in_en    = 1'b0;
      count_out_en   = 1'b0;
      case (state)
         ss_shift_in: begin
            shift_fifo  = 1'b1;
            en_infifo   = 1'b1;
            count_in_en = 1'b1;
         end
         ss_last_in: begin
            shift_fifo     = 1'b1;
            en_infifo      = 1'b1;
            data_in_finish = 1'b1;
         end
         ss_hold: begin
            hold_fifo = 1'b1;
            hold_synd = 1'b1;
         end
         ss_out_prepare: begin
            hold_fifo    = 1'b1;
            count_out_en = 1'b1;
         end
         // Receive waits one word so the new window ends no earlier than the output
         ss_out_first, ss_overlap_first: begin
            shift_fifo     = 1'b1;
            data_out_start = 1'b1;
            count_out_en   = 1'b1;
         end
         ss_out_shift: begin
            shift_fifo   = 1'b1;
            count_out_en = 1'b1;
         end
         ss_out_done:
            data_out_end = 1'b1;
         ss_overlap_shift: begin
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            count_in_en  = 1'b1;
            count_out_en = 1'b1;
         end
         ss_overlap_done_full: begin
            shift_fifo     = 1'b1;
            en_infifo      = 1'b1;
            data_in_finish = 1'b1;
            data_out_end   = 1'b1;
         end
         ss_overlap_done_partial: begin
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            count_in_en  = 1'b1;
            data_out_end = 1'b1;
         end
         default:
            shift_fifo = 1'b0;
      endcase
   end

   a_shift_hold_exclusive: assert property (
      @(posedge clock1) disable iff (!reset) !(shift_fifo && hold_fifo));

endmodule

// File: source/rs_word_counters.sv
// Reed-Solomon receive and output word counters
// Time the receive and output windows and flag their last words
`timescale 1ns/1ps

module rs_word_counters (
   input  logic clock1,
   input  logic reset,
   input  logic count_in_en,
   input  logic count_out_en,
   output logic last_word_in,
   output logic last_word_out,
   output logic last_data_out,
   output logic eval_error
);
   import rs_ctrl_pkg::*;

   logic [WORD_COUNT_W-1:0] count_in;
   logic [WORD_COUNT_W-1:0] count_out;

   // Each counter restarts from zero whenever its window closes
   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         count_in  <= '0;
         count_out <= '0;
      end else begin
         if (count_in_en) begin
            count_in <= count_in + 1'b1;
         end else begin
            count_in <= '0;
         end
         if (count_out_en) begin
            count_out <= count_out + 1'b1;
         end else begin
            count_out <= '0;
         end
      end
   end

   // Last shift_in word, one more follows in last_in
   assign last_word_in  = (count_in == WORD_COUNT_W'(CODEWORD_LEN - 2));
   assign last_word_out = &count_out;
   assign last_data_out = last_word_out;
   assign eval_error    = count_out_en;

endmodule

// File: src.f
source/rs_ctrl_pkg.sv
source/rs_word_counters.sv
source/rs_stream_sequencer.sv
source/rs_decode_sequencer.sv
source/rs_main_control.sv
verif/tb_clock_gen.sv
verif/rs_main_control_tb.sv

// File: verif/rs_ctrl_patterns.txt
// err_detect _ kes_delay _ lambda_degree _ root_count _ second_start _ expected_decode_fail
// Hex fields where kes_delay counts extra solving cycles before finish_kes
0_00_0_0_0_0
1_03_2_2_0_0
1_06_3_1_0_1
0_00_5_2_0_0
1_00_4_4_1_0
0_00_0_0_1_0
1_0a_2_3_1_1
1_01_1_1_0_0

// File: verif/rs_main_control_tb.sv
// Reed-Solomon main control testbench
// Runs the codeword cases of the pattern file through the controller and
// checks handshakes, window lengths and the decode status
`timescale 1ns/1ps

module rs_main_control_tb;
   import rs_ctrl_pkg::*;

   logic                clock1;
   logic                reset;
   logic                start;
   logic                err_detect;
   logic                finish_kes;
   logic [DEGREE_W-1:0] root_count;
   logic [DEGREE_W-1:0] lambda_degree;
   logic                ready;
   logic                active_sc;
   logic                active_kes;
   logic                active_csee;
   logic                eval_synd;
   logic                hold_synd;
   logic                err_found;
   logic                decode_fail;
   logic                data_out_start;
   logic                data_out_end;
   logic                shift_fifo;
   logic                hold_fifo;
   logic                en_infifo;
   logic                en_outfifo;
   logic                last_data_out;
   logic                eval_error;

   // err_detect, kes_delay, lambda_degree, root_count, second start, expected decode_fail
   logic [27:0] patterns [0:15];
   string       case_tag;
   int          check_errors;
   int          timeout_errors;
   int          cycle_index;
   int          in_run;
   int          out_run;
   int          in_windows;
   int          out_windows;
   int          out_end_count;
   int          kes_cycles;
   int          err_found_cycles;
   int          csee_cycles;
   int          fail_cycles;
   int          sc_in_output;
   int          csee_first;
   int          outfifo_first;
   logic        in_last_finish;

   tb_clock_gen i_tb_clock_gen (
      .clock1 (clock1),
      .reset  (reset)
   );

   rs_main_control i_rs_main_control (.*);

   function automatic logic [14:0] control_bits();
      return {active_sc, active_kes, active_csee, eval_synd, hold_synd, err_found,
              decode_fail, data_out_start, data_out_end, shift_fifo, hold_fifo,
              en_infifo, en_outfifo, last_data_out, eval_error};
   endfunction

   function automatic logic output_bit(input string name);
      logic value;
      value = 1'b0;
      if (name == "ready") value = ready;
      else if (name == "eval_synd") value = eval_synd;
      else if (name == "err_found") value = err_found;
      else if (name == "eval_error") value = eval_error;
      else if (name == "data_out_end") value = data_out_end;
      return value;
   endfunction

   task automatic report_mismatch(input string name, input int expected, input int actual);
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      check_errors++;
   endtask

   // Starts and returns on a falling edge once the output is high
   task automatic wait_for_high(input string name, input int limit);
      int n;
      n = 0;
      while (!output_bit(name) && n < limit) begin
         @(posedge clock1);
         @(negedge clock1);
         n++;
      end
      if (!output_bit(name)) begin
         $display("Timeout in %s while waiting for %s to rise", case_tag, name);
         timeout_errors++;
      end
   endtask

   task automatic clear_tallies();
      cycle_index      = 0;
      in_windows       = 0;
      out_windows      = 0;
      out_end_count    = 0;
      kes_cycles       = 0;
      err_found_cycles = 0;
      csee_cycles      = 0;
      fail_cycles      = 0;
      sc_in_output     = 0;
      csee_first       = -1;
      outfifo_first    = -1;
   endtask

   // Output monitor that tallies events and checks window lengths on every falling edge
   always @(negedge clock1) begin
      if (!reset) begin
         if (!ready || control_bits() != '0)
            report_mismatch("reset_idle_outputs", 32'h8000, {ready, control_bits()});
      end else begin
         cycle_index++;
         if (en_infifo) begin
            in_run++;
            in_last_finish = data_in_finish_seen();
         end else if (in_run != 0) begin
            if (in_run != CODEWORD_LEN)
               report_mismatch({case_tag, " en_infifo_window"}, CODEWORD_LEN, in_run);
            if (!in_last_finish)
               report_mismatch({case_tag, " data_in_finish_last"}, 1, 0);
            in_windows++;
            in_run = 0;
         end
         if (eval_error) begin
            out_run++;
            if ((out_run == 2) != data_out_start)
               report_mismatch({case_tag, " data_out_start"}, int'(out_run == 2),
                               data_out_start);
         end else if (out_run != 0) begin
            if (out_run != CODEWORD_LEN + 1)
               report_mismatch({case_tag, " eval_error_window"}, CODEWORD_LEN + 1, out_run);
            if (!data_out_end)
               report_mismatch({case_tag, " data_out_end_after_window"}, 1, 0);
            out_windows++;
            out_run = 0;
         end
         // Last output word is the final cycle of the eval_error window
         if (last_data_out != (eval_error && out_run == CODEWORD_LEN + 1))
            report_mismatch({case_tag, " last_data_out"},
                            int'(eval_error && out_run == CODEWORD_LEN + 1), last_data_out);
         if (shift_fifo && hold_fifo)
            report_mismatch({case_tag, " shift_hold_exclusive"}, 0, 1);
         if (hold_synd && (en_infifo || eval_error))
            report_mismatch({case_tag, " hold_synd_outside_hold"}, 0, 1);
         if (data_out_end) out_end_count++;
         if (active_kes) kes_cycles++;
         if (err_found) err_found_cycles++;
         if (active_csee) csee_cycles++;
         if (decode_fail) fail_cycles++;
         if (active_sc && eval_error) sc_in_output++;
         if (active_csee && csee_first < 0) csee_first = cycle_index;
         if (en_outfifo && outfifo_first < 0) outfifo_first = cycle_index;
      end
   end

   // The last received word is flagged by the internal finish strobe
   function automatic logic data_in_finish_seen();
      return i_rs_main_control.data_in_finish;
   endfunction

   task automatic run_case(input int idx);
      logic pat_err;
      int   kes_delay;
      logic second;
      logic exp_fail;
      int   windows;
      pat_err   = patterns[idx][24];
      kes_delay = patterns[idx][23:16];
      second    = patterns[idx][4];
      exp_fail  = patterns[idx][0];
      windows   = second ? 2 : 1;
      wait_for_high("ready", 100);
      @(posedge clock1);
      case_tag = $sformatf("case%0d", idx);
      clear_tallies();
      start         <= 1'b1;
      err_detect    <= pat_err;
      lambda_degree <= patterns[idx][14:12];
      root_count    <= patterns[idx][10:8];
      @(negedge clock1);
      @(posedge clock1);
      start <= 1'b0;
      @(negedge clock1);
      if (!active_sc) report_mismatch({case_tag, " active_sc_after_start"}, 1, active_sc);
      wait_for_high("eval_synd", 100);
      if (pat_err) begin
         wait_for_high("err_found", 4);
         repeat (kes_delay) begin
            @(posedge clock1);
            @(negedge clock1);
            if (!active_kes) report_mismatch({case_tag, " active_kes_hold"}, 1, active_kes);
         end
         @(posedge clock1);
         finish_kes <= 1'b1;
         @(negedge clock1);
         @(posedge clock1);
         finish_kes <= 1'b0;
         @(negedge clock1);
         if (!(active_kes && active_csee))
            report_mismatch({case_tag, " search_start"}, 3, {active_kes, active_csee});
      end
      wait_for_high("eval_error", 10);
      if (second) begin
         repeat (3) begin
            @(posedge clock1);
            @(negedge clock1);
         end
         // Next codeword is clean
         @(posedge clock1);
         start      <= 1'b1;
         err_detect <= 1'b0;
         @(negedge clock1);
         @(posedge clock1);
         start <= 1'b0;
         @(negedge clock1);
      end
      wait_for_high("data_out_end", 60);
      @(posedge clock1);
      @(negedge clock1);
      if (decode_fail != exp_fail)
         report_mismatch({case_tag, " decode_fail"}, exp_fail, decode_fail);
      if (!second && !ready) report_mismatch({case_tag, " ready_after_output"}, 1, ready);
      if (second) begin
         wait_for_high("eval_error", 100);
         wait_for_high("data_out_end", 60);
         @(posedge clock1);
         @(negedge clock1);
         if (!ready) report_mismatch({case_tag, " ready_after_second"}, 1, ready);
      end
      @(posedge clock1);
      if (in_windows != windows) report_mismatch({case_tag, " in_windows"}, windows, in_windows);
      if (out_windows != windows)
         report_mismatch({case_tag, " out_windows"}, windows, out_windows);
      if (out_end_count != windows)
         report_mismatch({case_tag, " data_out_end_pulses"}, windows, out_end_count);
      if (err_found_cycles != pat_err)
         report_mismatch({case_tag, " err_found_pulses"}, pat_err, err_found_cycles);
      if (csee_cycles != pat_err)
         report_mismatch({case_tag, " active_csee_pulses"}, pat_err, csee_cycles);
      if (kes_cycles != (pat_err ? kes_delay + 3 : 0))
         report_mismatch({case_tag, " active_kes_cycles"}, pat_err ? kes_delay + 3 : 0,
                         kes_cycles);
      if (fail_cycles != exp_fail)
         report_mismatch({case_tag, " decode_fail_cycles"}, exp_fail, fail_cycles);
      if (sc_in_output != second)
         report_mismatch({case_tag, " active_sc_in_output"}, second, sc_in_output);
      if (pat_err && !(csee_first >= 0 && csee_first < outfifo_first))
         report_mismatch({case_tag, " csee_before_outfifo"}, 1, 0);
      @(negedge clock1);
   endtask

   initial begin
      int n;
      int cases_run;
      start          = 1'b0;
      err_detect     = 1'b0;
      finish_kes     = 1'b0;
      root_count     = '0;
      lambda_degree  = '0;
      check_errors   = 0;
      timeout_errors = 0;
      in_run         = 0;
      out_run        = 0;
      in_last_finish = 1'b0;
      cases_run      = 0;
      case_tag       = "reset";
      clear_tallies();
      $readmemh("verif/rs_ctrl_patterns.txt", patterns);
      n = 0;
      while (!reset && n < 20) begin
         @(negedge clock1);
         n++;
      end
      if (!reset) begin
         $display("Timeout while waiting for reset to be released");
         timeout_errors++;
      end
      repeat (3) begin
         @(negedge clock1);
         if (!ready || control_bits() != '0)
            report_mismatch("after_reset_idle_outputs", 32'h8000, {ready, control_bits()});
      end
      for (int i = 0; i < 16; i++) begin
         if ($isunknown(patterns[i]) || timeout_errors != 0) break;
         run_case(i);
         cases_run++;
      end
      if (cases_run == 0) begin
         $display("No test cases were read from the pattern file");
         check_errors++;
      end
      $display("Check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns clock1 and an active low reset held for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clock1,
   output logic reset
);

   initial begin
      clock1 = 1'b0;
      forever #4 clock1 = ~clock1;
   end

   initial begin
      reset = 1'b0;
      repeat (8) @(posedge clock1);
      reset <= 1'b1;
   end

endmodule
